/* hw/lsu.sv */
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue,
    input  uop_t       uop,
    input  operands_t  operands,
    input  logic       fireStore,
    input  logic       flush,
    output logic       rBusy,
    output logic       wBusy,
    output logic       memReqValid,
    output memReq_t    memReq,
    input  logic       memReqReady,
    input  logic       memRespValid,
    input  memResp_t   memResp,
    output prfWrite_t  prfWrite,
    output robReport_t robReport
);

    word_t      vaddr;
    word_t      paddr;
    size_e      size;
    logic       isLoad;
    logic       isStore;
    logic       signExt;
    logic       addrErr;
    logic       halt;
    logic       loadStrobe;
    logic       storeStrobe;
    logic       wbFull;
    logic       rbBusy;
    logic       hazard;
    memAccess_t access;
    robReport_t issueReport;
    logic       issueValid;
    logic       rdReqValid;
    memReq_t    rdReq;
    logic       rdGrant;
    logic       wrReqValid;
    memReq_t    wrReq;
    logic       wrGrant;
    logic       rdRespValid;
    memResp_t   rdResp;
    logic       loadDone;
    robId_t     loadId;

    // ##################################################################
    // address generation and decode
    // ##################################################################

    assign vaddr = operands.base + uop.imm;
    // kseg0 and kseg1 are unmapped.
    assign paddr = (vaddr[31:30] == 2'b10) ? {3'b000, vaddr[28:0]} : vaddr;

    always_comb begin
        isLoad  = 1'b0;
        isStore = 1'b0;
        signExt = 1'b0;
        size    = sWord;
        case (uop.kind)
            LB:  begin isLoad = 1'b1; signExt = 1'b1; size = sByte; end
            LBU: begin isLoad = 1'b1; size = sByte; end
            LH:  begin isLoad = 1'b1; signExt = 1'b1; size = sHalf; end
            LHU: begin isLoad = 1'b1; size = sHalf; end
            LW:  begin isLoad = 1'b1; signExt = 1'b1; end
            SB:  begin isStore = 1'b1; size = sByte; end
            SH:  begin isStore = 1'b1; size = sHalf; end
            SW:  isStore = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (size)
            sHalf:   addrErr = vaddr[0];
            sWord:   addrErr = |vaddr[1:0];
            default: addrErr = 1'b0;
        endcase
        if (!(isLoad || isStore))
            addrErr = 1'b0;
    end

    assign loadStrobe  = issue & isLoad & ~addrErr & ~halt;
    assign storeStrobe = issue & isStore & ~addrErr & ~halt;

    assign access.addr    = paddr;
    assign access.size    = size;
    assign access.signExt = signExt;
    assign access.data    = operands.storeData;
    assign access.id      = uop.id;
    assign access.rd      = uop.rd;

    // loads report later, everything else finishes at issue.
    assign issueValid = issue & ~halt & (~isLoad | addrErr);

    assign issueReport.setFinish     = 1'b1;
    assign issueReport.id            = uop.id;
    assign issueReport.setException  = addrErr;
    assign issueReport.exceptionType = isStore ? ExcAddrErrS : ExcAddrErrL;
    assign issueReport.badVAddr      = vaddr;

    assign rBusy = rbBusy | halt;
    assign wBusy = wbFull | halt;

    // ##################################################################
    // buffers, arbiter and rob port
    // ##################################################################

    write_buffer u_wbuf (
        .clk(clk), .rst(rst),
        .push(storeStrobe), .entry(access),
        .commit(fireStore), .flush(flush),
        .loadAddr(rdReq.addr), .hazard(hazard), .full(wbFull),
        .drainValid(wrReqValid), .drainReq(wrReq), .drainGrant(wrGrant)
    );

    read_buffer u_rbuf (
        .clk(clk), .rst(rst),
        .load(loadStrobe), .entry(access), .hazard(hazard), .busy(rbBusy),
        .reqValid(rdReqValid), .req(rdReq), .grant(rdGrant),
        .respValid(rdRespValid), .resp(rdResp),
        .prfWrite(prfWrite), .doneId(loadId), .done(loadDone)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .rdValid(rdReqValid), .rdReq(rdReq), .rdGrant(rdGrant),
        .wrValid(wrReqValid), .wrReq(wrReq), .wrGrant(wrGrant),
        .memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
        .memRespValid(memRespValid), .memResp(memResp),
        .rdRespValid(rdRespValid), .rdResp(rdResp)
    );

    rob_talker u_talker (
        .clk(clk), .rst(rst),
        .issueReport(issueReport), .issueValid(issueValid),
        .loadDone(loadDone), .loadId(loadId),
        .robReport(robReport), .halt(halt)
    );

    // the core must respect wBusy.
    storeWhileFull: assert property (@(posedge clk) disable iff (rst)
        storeStrobe |-> !wbFull)
        else $error("store issued into a full write buffer.");

endmodule

/* hw/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ######################################################################
// load/store unit sizing.
// ######################################################################

// data and address width.
`define LSU_DATA_W    32

// reorder buffer tag width.
`define LSU_ROB_ID_W  5

`define LSU_PREG_W    6     // physical register index.

// store queue entries, power of two.
`define LSU_WB_DEPTH  4

`endif

/* hw/lsu_pkg.sv */
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_DATA_W-1:0]   word_t;
    typedef logic [`LSU_ROB_ID_W-1:0] robId_t;
    typedef logic [`LSU_PREG_W-1:0]   pregId_t;
    typedef logic [3:0]               strobe_t;

    typedef enum logic [3:0] {LB, LBU, LH, LHU, LW, SB, SH, SW, NOP} uopKind_e;
    typedef enum logic [1:0] {sByte, sHalf, sWord} size_e;

    // mips cause codes for address errors.
    typedef enum logic [4:0] {
        ExcAddrErrL = 5'd4,
        ExcAddrErrS = 5'd5
    } excCode_e;

    typedef struct packed {
        uopKind_e kind;
        robId_t   id;
        pregId_t  rd;
        word_t    imm;          // already sign extended.
    } uop_t;

    typedef struct packed {
        word_t base;
        word_t storeData;
    } operands_t;

    typedef struct packed {
        word_t   addr;          // physical.
        size_e   size;
        logic    signExt;
        word_t   data;
        robId_t  id;
        pregId_t rd;
    } memAccess_t;

    typedef struct packed {
        word_t   addr;
        logic    wen;
        word_t   data;
        strobe_t strobe;
    } memReq_t;

    typedef struct packed {
        word_t data;
    } memResp_t;

    typedef struct packed {
        logic    wen;
        pregId_t rd;
        word_t   wdata;
    } prfWrite_t;

    typedef struct packed {
        logic     setFinish;
        robId_t   id;
        logic     setException;
        excCode_e exceptionType;
        word_t    badVAddr;
    } robReport_t;

    // byte enables of an access inside its word.
    function automatic strobe_t byteStrobe(size_e size, logic [1:0] offset);
        strobe_t s;
        case (size)
            sByte:   s = strobe_t'(4'b0001 << offset);
            sHalf:   s = offset[1] ? 4'b1100 : 4'b0011;
            default: s = 4'b1111;
        endcase
        return s;
    endfunction

endpackage

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdValid,
    input  memReq_t  rdReq,
    output logic     rdGrant,
    input  logic     wrValid,
    input  memReq_t  wrReq,
    output logic     wrGrant,
    output logic     memReqValid,
    output memReq_t  memReq,
    input  logic     memReqReady,
    input  logic     memRespValid,
    input  memResp_t memResp,
    output logic     rdRespValid,
    output memResp_t rdResp
);

    logic locked;       // a request is on the port, waiting for ready.
    logic lockRd;
    logic selRd;
    logic fire;
    logic rdPending;

    // reads win unless a write is already presented.
    assign selRd = locked ? lockRd : rdValid;

    assign memReqValid = selRd ? rdValid : wrValid;
    assign memReq      = selRd ? rdReq : wrReq;
    assign fire        = memReqValid & memReqReady;
    assign rdGrant     = fire & selRd;
    assign wrGrant     = fire & ~selRd;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            lockRd <= 1'b0;
        end else if (memReqValid && !memReqReady) begin
            locked <= 1'b1;
            lockRd <= selRd;
        end else if (fire) begin
            locked <= 1'b0;
        end
    end

    // ##################################################################
    // response routing
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPending <= 1'b0;
        end else if (rdGrant) begin
            rdPending <= 1'b1;
        end else if (memRespValid) begin
            rdPending <= 1'b0;
        end
    end

    assign rdRespValid = memRespValid & rdPending;
    assign rdResp      = memResp;

endmodule

/* hw/read_buffer.sv */
`timescale 1ns/1ps

module read_buffer import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  memAccess_t entry,
    input  logic       hazard,
    output logic       busy,
    output logic       reqValid,
    output memReq_t    req,
    input  logic       grant,
    input  logic       respValid,
    input  memResp_t   resp,
    output prfWrite_t  prfWrite,
    output robId_t     doneId,
    output logic       done
);

    typedef enum logic [2:0] {
        idle,
        waitHazard,
        request,
        waitResp,
        writeBack
    } state_e;

    state_e     state;
    state_e     nextState;
    memAccess_t held;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    word_t      loadData;

    // ##################################################################
    // control
    // ##################################################################

    always_comb begin
        nextState = state;
        case (state)
            idle:       if (load) nextState = waitHazard;
            waitHazard: if (!hazard) nextState = request;   // older stores first.
            request:    if (grant) nextState = waitResp;
            waitResp:   if (respValid) nextState = writeBack;
            writeBack:  nextState = idle;
            default:    nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && load) begin
            held <= entry;
        end
    end

    assign busy     = state != idle;
    assign reqValid = state == request;

    assign req.addr   = held.addr;
    assign req.wen    = 1'b0;
    assign req.data   = '0;
    assign req.strobe = byteStrobe(held.size, held.addr[1:0]);

    // ##################################################################
    // lane select and extension
    // ##################################################################

    always_comb begin
        byteLane = resp.data[{held.addr[1:0], 3'b000} +: 8];
        halfLane = held.addr[1] ? resp.data[31:16] : resp.data[15:0];
        case (held.size)
            sByte:   loadData = {{24{held.signExt & byteLane[7]}}, byteLane};
            sHalf:   loadData = {{16{held.signExt & halfLane[15]}}, halfLane};
            default: loadData = resp.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prfWrite.wen <= 1'b0;
        end else begin
            prfWrite.wen <= state == waitResp && respValid;
        end
        if (respValid) begin
            prfWrite.rd    <= held.rd;
            prfWrite.wdata <= loadData;
        end
    end

    assign done   = state == writeBack;
    assign doneId = held.id;

    respOutsideWait: assert property (@(posedge clk) disable iff (rst)
        respValid |-> state == waitResp)
        else $error("read response with no load waiting.");

endmodule

/* hw/rob_talker.sv */
`timescale 1ns/1ps

module rob_talker import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  robReport_t issueReport,
    input  logic       issueValid,
    input  logic       loadDone,
    input  robId_t     loadId,
    output robReport_t robReport,
    output logic       halt
);

    logic   heldValid;
    robId_t heldId;

    // ##################################################################
    // one report per cycle, issue side first
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            robReport.setFinish <= 1'b0;
            heldValid           <= 1'b0;
        end else if (issueValid) begin
            robReport <= issueReport;
            heldValid <= loadDone;          // load finish waits a cycle.
        end else if (heldValid || loadDone) begin
            robReport.setFinish    <= 1'b1;
            robReport.id           <= heldValid ? heldId : loadId;
            robReport.setException <= 1'b0;
            heldValid              <= heldValid & loadDone;
        end else begin
            robReport.setFinish    <= 1'b0;
            robReport.setException <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (loadDone) begin
            heldId <= loadId;
        end
    end

    // blocks further issue until the held finish is out.
    assign halt = heldValid;

endmodule

/* hw/write_buffer.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module write_buffer import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  memAccess_t entry,
    input  logic       commit,
    input  logic       flush,
    input  word_t      loadAddr,
    output logic       hazard,
    output logic       full,
    output logic       drainValid,
    output memReq_t    drainReq,
    input  logic       drainGrant
);

    localparam int Depth = `LSU_WB_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    typedef logic [PtrW:0] ptr_t;   // top bit marks the wrap.

    memAccess_t slots [Depth];
    ptr_t       headPtr;
    ptr_t       cmtPtr;
    ptr_t       tailPtr;
    ptr_t       count;
    memAccess_t headEntry;
    word_t      laneData;

    assign count      = tailPtr - headPtr;
    assign full       = count == ptr_t'(Depth);
    assign drainValid = cmtPtr != headPtr;      // committed, not yet drained.
    assign headEntry  = slots[headPtr[PtrW-1:0]];

    // ##################################################################
    // drain request
    // ##################################################################

    always_comb begin
        case (headEntry.size)
            sByte:   laneData = {4{headEntry.data[7:0]}};
            sHalf:   laneData = {2{headEntry.data[15:0]}};
            default: laneData = headEntry.data;
        endcase
    end

    assign drainReq.addr   = headEntry.addr;
    assign drainReq.wen    = 1'b1;
    assign drainReq.data   = laneData;
    assign drainReq.strobe = byteStrobe(headEntry.size, headEntry.addr[1:0]);

    // ##################################################################
    // overlap check against the waiting load
    // ##################################################################

    always_comb begin
        ptr_t idx;
        hazard = 1'b0;
        for (int k = 0; k < Depth; k++) begin
            idx = headPtr + ptr_t'(k);
            if (ptr_t'(k) < count &&
                slots[idx[PtrW-1:0]].addr[31:2] == loadAddr[31:2]) begin
                hazard = 1'b1;
            end
        end
    end

    // ##################################################################
    // pointers and storage
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            cmtPtr  <= '0;
            tailPtr <= '0;
        end else begin
            if (drainGrant) begin
                headPtr <= headPtr + ptr_t'(1);
            end
            if (commit) begin
                cmtPtr <= cmtPtr + ptr_t'(1);
            end
            if (flush) begin
                tailPtr <= cmtPtr;              // drop uncommitted stores.
            end else if (push) begin
                tailPtr <= tailPtr + ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[tailPtr[PtrW-1:0]] <= entry;
        end
    end

    // the rob only commits stores it has seen issue.
    commitPastTail: assert property (@(posedge clk) disable iff (rst)
        commit |-> cmtPtr != tailPtr)
        else $error("store commit with no uncommitted entry.");

endmodule

/* lsu.f */
+incdir+hw
hw/lsu_pkg.sv
hw/write_buffer.sv
hw/read_buffer.sv
hw/mem_arbiter.sv
hw/rob_talker.sv
hw/lsu.sv
verification/lsu_mem_model.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f lsu.f -o Vlsu_tb

./obj_dir/Vlsu_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

/* verification/lsu_mem_model.sv */
`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     memReqValid,
    input  memReq_t  memReq,
    output logic     memReqReady,
    output logic     memRespValid,
    output memResp_t memResp
);

    word_t      mem [256];
    word_t      rngState;
    word_t      rngNext;
    logic       readPending;
    logic [1:0] delay;
    word_t      readData;

    function automatic word_t lcgStep(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every byte depends on the word index.
    function automatic word_t initWord(input int idx);
        return {8'(idx) ^ 8'hA5, 8'(idx * 7), ~8'(idx), 8'(idx) + 8'h3C};
    endfunction

    assign rngNext = lcgStep(rngState);

    always_ff @(posedge clk) begin
        if (rst) begin
            rngState     <= 32'd97;
            memReqReady  <= 1'b0;
            memRespValid <= 1'b0;
            readPending  <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= initWord(i);
            end
        end else begin
            rngState     <= rngNext;
            memReqReady  <= rngNext[17:16] != 2'b00;   // ready three cycles in four.
            memRespValid <= 1'b0;
            if (memReqValid && memReqReady) begin
                if (memReq.wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (memReq.strobe[b]) begin
                            mem[memReq.addr[9:2]][8*b +: 8] <= memReq.data[8*b +: 8];
                        end
                    end
                end else begin
                    readPending <= 1'b1;
                    readData    <= mem[memReq.addr[9:2]];
                    delay       <= rngNext[21:20];
                end
            end
            if (readPending) begin
                if (delay == 2'd0) begin
                    memRespValid <= 1'b1;
                    memResp.data <= readData;
                    readPending  <= 1'b0;
                end else begin
                    delay <= delay - 2'd1;
                end
            end
        end
    end

endmodule

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int Timeout = 400;

    typedef struct packed {
        word_t addr;
        size_e size;
        word_t data;
    } storeRec_t;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       issue;
    uop_t       uop;
    operands_t  operands;
    logic       fireStore;
    logic       flush;
    logic       rBusy;
    logic       wBusy;
    logic       memReqValid;
    memReq_t    memReq;
    logic       memReqReady;
    logic       memRespValid;
    memResp_t   memResp;
    prfWrite_t  prfWrite;
    robReport_t robReport;

    word_t     refMem [256];
    storeRec_t pending [$];
    logic      outstanding [32];
    logic      expErr [32];
    logic      expLoad [32];
    excCode_e  expCode [32];
    word_t     expBad [32];
    logic      loadPending;
    logic      issuedAny;
    pregId_t   expRd;
    word_t     expData;
    word_t     expPaddr;
    word_t     rngState = 32'd97;
    robId_t    nextId = '0;

    always #20 clk = ~clk;

    lsu u_dut (
        .clk(clk), .rst(rst), .issue(issue), .uop(uop), .operands(operands),
        .fireStore(fireStore), .flush(flush), .rBusy(rBusy), .wBusy(wBusy),
        .memReqValid(memReqValid), .memReq(memReq), .memReqReady(memReqReady),
        .memRespValid(memRespValid), .memResp(memResp),
        .prfWrite(prfWrite), .robReport(robReport)
    );

    lsu_mem_model u_mem (
        .clk(clk), .rst(rst), .memReqValid(memReqValid), .memReq(memReq),
        .memReqReady(memReqReady), .memRespValid(memRespValid), .memResp(memResp)
    );

    // ##################################################################
    // reference rules
    // ##################################################################

    function automatic word_t patternWord(input int idx);
        return {8'(idx) ^ 8'hA5, 8'(idx * 7), ~8'(idx), 8'(idx) + 8'h3C};
    endfunction

    function automatic word_t lcgStep(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic nextRand(output word_t r);
        rngState = lcgStep(rngState);
        r = rngState;
    endtask

    function automatic logic isLoadKind(input uopKind_e k);
        return k == LB || k == LBU || k == LH || k == LHU || k == LW;
    endfunction

    function automatic size_e kindSize(input uopKind_e k);
        if (k == LB || k == LBU || k == SB)
            return sByte;
        if (k == LH || k == LHU || k == SH)
            return sHalf;
        return sWord;
    endfunction

    function automatic logic misaligned(input size_e s, input word_t a);
        return (s == sHalf && a[0]) || (s == sWord && a[1:0] != 2'b00);
    endfunction

    // kseg0/kseg1 lose the top three bits.
    function automatic word_t mapAddr(input word_t v);
        return (v >= 32'h8000_0000 && v <= 32'hBFFF_FFFF) ? (v & 32'h1FFF_FFFF) : v;
    endfunction

    function automatic word_t extendLoad(input uopKind_e k, input word_t w, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{off, 3'b000} +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (k)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return w;
        endcase
    endfunction

    function automatic word_t mergeStore(input word_t old, input storeRec_t s);
        word_t m;
        m = old;
        case (s.size)
            sByte:   m[{s.addr[1:0], 3'b000} +: 8] = s.data[7:0];
            sHalf: begin
                if (s.addr[1])
                    m[31:16] = s.data[15:0];
                else
                    m[15:0] = s.data[15:0];
            end
            default: m = s.data;
        endcase
        return m;
    endfunction

    function automatic logic strobeMatches(input memReq_t r);
        if (r.strobe == 4'b1111 || r.strobe == 4'b0011)
            return r.addr[1:0] == 2'b00;
        if (r.strobe == 4'b1100)
            return r.addr[1:0] == 2'b10;
        return r.strobe == (4'b0001 << r.addr[1:0]);
    endfunction

    task automatic failCheck(input string name, input word_t expVal, input word_t actVal);
        $display("FAIL %s expected %h actual %h", name, expVal, actVal);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // ##################################################################
    // expectation tracking from the driven inputs
    // ##################################################################

    always @(posedge clk) begin
        storeRec_t rec;
        word_t     va;
        word_t     pa;
        size_e     sz;
        logic      err;
        if (rst) begin
            loadPending <= 1'b0;
            issuedAny   <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                refMem[i] <= patternWord(i);
            end
            for (int i = 0; i < 32; i++) begin
                outstanding[i] <= 1'b0;
            end
        end else begin
            if (robReport.setFinish)
                outstanding[robReport.id] <= 1'b0;
            if (prfWrite.wen)
                loadPending <= 1'b0;
            if (fireStore) begin
                rec = pending.pop_front();
                refMem[rec.addr[9:2]] <= mergeStore(refMem[rec.addr[9:2]], rec);
            end
            if (flush)
                pending.delete();       // uncommitted stores never land.
            if (issue) begin
                va  = operands.base + uop.imm;
                pa  = mapAddr(va);
                sz  = kindSize(uop.kind);
                err = misaligned(sz, va);
                issuedAny <= 1'b1;
                outstanding[uop.id] <= 1'b1;
                expErr[uop.id]  <= err;
                expLoad[uop.id] <= isLoadKind(uop.kind);
                expCode[uop.id] <= isLoadKind(uop.kind) ? ExcAddrErrL : ExcAddrErrS;
                expBad[uop.id]  <= va;
                if (!err && isLoadKind(uop.kind)) begin
                    loadPending <= 1'b1;
                    expRd       <= uop.rd;
                    expPaddr    <= pa;
                    expData     <= extendLoad(uop.kind, refMem[pa[9:2]], va[1:0]);
                end
                if (!err && !isLoadKind(uop.kind)) begin
                    rec.addr = pa;
                    rec.size = sz;
                    rec.data = operands.storeData;
                    pending.push_back(rec);
                end
            end
        end
    end

    // ##################################################################
    // checks
    // ##################################################################

    quietAfterReset: assert property (@(posedge clk) disable iff (rst)
        !issuedAny |-> {memReqValid, prfWrite.wen, robReport.setFinish, rBusy, wBusy} == 5'b0)
        else failCheck("quietAfterReset", 0,
            32'($sampled({memReqValid, prfWrite.wen, robReport.setFinish, rBusy, wBusy})));

    loadWriteback: assert property (@(posedge clk) disable iff (rst)
        prfWrite.wen |-> loadPending && prfWrite.wdata == expData)
        else failCheck("loadWriteback", $sampled(expData), $sampled(prfWrite.wdata));

    loadDestReg: assert property (@(posedge clk) disable iff (rst)
        prfWrite.wen |-> prfWrite.rd == expRd)
        else failCheck("loadDestReg", 32'($sampled(expRd)), 32'($sampled(prfWrite.rd)));

    finishOnce: assert property (@(posedge clk) disable iff (rst)
        robReport.setFinish |-> outstanding[robReport.id])
        else failCheck("finishOnce", 1, 0);

    exceptionFlag: assert property (@(posedge clk) disable iff (rst)
        robReport.setFinish |-> robReport.setException == expErr[robReport.id])
        else failCheck("exceptionFlag", 32'($sampled(expErr[robReport.id])),
            32'($sampled(robReport.setException)));

    exceptionCode: assert property (@(posedge clk) disable iff (rst)
        robReport.setFinish && robReport.setException |->
            robReport.exceptionType == expCode[robReport.id])
        else failCheck("exceptionCode", 32'($sampled(expCode[robReport.id])),
            32'($sampled(robReport.exceptionType)));

    exceptionAddr: assert property (@(posedge clk) disable iff (rst)
        robReport.setFinish && robReport.setException |->
            robReport.badVAddr == expBad[robReport.id])
        else failCheck("exceptionAddr", $sampled(expBad[robReport.id]),
            $sampled(robReport.badVAddr));

    finishAfterWriteback: assert property (@(posedge clk) disable iff (rst)
        robReport.setFinish && expLoad[robReport.id] && !expErr[robReport.id] |-> !loadPending)
        else failCheck("finishAfterWriteback", 0, 1);

    requestMapped: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> memReq.addr[31:29] == 3'b000)
        else failCheck("requestMapped", 0, 32'($sampled(memReq.addr[31:29])));

    strobeAligned: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> strobeMatches(memReq))
        else failCheck("strobeAligned", 32'($sampled(memReq.strobe)), $sampled(memReq.addr));

    loadAddress: assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReq.wen |-> memReq.addr == expPaddr)
        else failCheck("loadAddress", $sampled(expPaddr), $sampled(memReq.addr));

    // ##################################################################
    // stimulus
    // ##################################################################

    task automatic issueOp(input uopKind_e kind, input word_t base, input word_t imm,
                           input word_t data, input pregId_t rd);
        int    waited;
        logic  ready;
        word_t pa;
        waited = 0;
        ready  = 1'b0;
        pa     = mapAddr(base + imm);
        while (!ready) begin
            @(posedge clk);
            // a store to the word of a running load waits, so its value stays fixed.
            if (isLoadKind(kind))
                ready = !outstanding[nextId] && !rBusy;
            else
                ready = !outstanding[nextId] && !wBusy &&
                        (!rBusy || pa[31:2] != expPaddr[31:2]);
            waited++;
            if (!ready && waited > Timeout)
                abortRun("timed out waiting for the LSU to accept an issue.");
        end
        issue    <= 1'b1;
        uop      <= '{kind: kind, id: nextId, rd: rd, imm: imm};
        operands <= '{base: base, storeData: data};
        @(posedge clk);
        issue  <= 1'b0;
        nextId = nextId + 5'd1;
    endtask

    task automatic commitStore();
        @(posedge clk);
        fireStore <= 1'b1;
        @(posedge clk);
        fireStore <= 1'b0;
    endtask

    task automatic flushStores();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic waitIdle();
        int   waited;
        logic busy;
        waited = 0;
        busy   = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = loadPending;
            for (int i = 0; i < 32; i++) begin
                busy = busy | outstanding[i];
            end
            waited++;
            if (busy && waited > Timeout)
                abortRun("timed out waiting for outstanding micro-ops to finish.");
        end
    endtask

    initial begin
        word_t    r;
        word_t    r2;
        word_t    d;
        word_t    base;
        word_t    imm;
        uopKind_e kind;
        issue     = 1'b0;
        uop       = '0;
        operands  = '0;
        fireStore = 1'b0;
        flush     = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (8) @(posedge clk);

        // each load flavour after a committed word store.
        for (int k = 0; k < 5; k++) begin
            nextRand(r);
            imm = {22'd0, r[9:2], 2'b00};
            issueOp(SW, 32'hA000_0000, imm, r ^ 32'h8000_8080, 6'd1);
            commitStore();
            kind = uopKind_e'(k);
            if (kindSize(kind) == sByte)
                imm = imm + {30'd0, r[11:10]};
            else if (kindSize(kind) == sHalf)
                imm = imm + {30'd0, r[11], 1'b0};
            issueOp(kind, 32'hA000_0000, imm, '0, pregId_t'(k + 2));
            waitIdle();
        end

        // misaligned accesses.
        issueOp(LH, 32'hA000_0000, 32'h11, '0, 6'd3);
        issueOp(LW, 32'h0000_0100, 32'h22, '0, 6'd4);
        issueOp(SH, 32'h8000_0000, 32'h33, 32'h1234, 6'd0);
        issueOp(SW, 32'hA000_0000, 32'h41, 32'h5678, 6'd0);
        waitIdle();

        // flushed stores leave the old value.
        issueOp(SW, 32'h0000_0000, 32'h80, 32'hDEAD_BEEF, 6'd0);
        issueOp(SB, 32'h0000_0000, 32'h81, 32'h55, 6'd0);
        flushStores();
        issueOp(LW, 32'hA000_0000, 32'h80, '0, 6'd9);
        waitIdle();

        // random mix under back-pressure, kept inside the model's 1 KB.
        for (int n = 0; n < 60; n++) begin
            nextRand(r);
            nextRand(r2);
            nextRand(d);
            kind = uopKind_e'(r[18:16]);
            case (r2[1:0])
                2'd0:    base = 32'h0000_0000;
                2'd1:    base = 32'h8000_0000;
                2'd2:    base = 32'hA000_0000;
                default: base = 32'hA000_0100;
            endcase
            imm = {23'd0, r2[10:2]};
            if (r2[13:12] != 2'b00) begin
                if (kindSize(kind) == sWord)
                    imm[1:0] = 2'b00;
                else if (kindSize(kind) == sHalf)
                    imm[0] = 1'b0;
            end
            issueOp(kind, base, imm, d, r[5:0]);
            if (!isLoadKind(kind) && !misaligned(kindSize(kind), base + imm)) begin
                if (r[20:19] != 2'b00)
                    commitStore();
                else
                    flushStores();
            end
        end
        waitIdle();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
